/* source/procPkg.sv */
/* Shared types, opcode encodings and host address map for the single-cycle core.
   Imported by each stage and by the host port. */
package procPkg;

	// Data, instruction and address all share one width
	typedef logic [15:0] word_t;
	typedef logic [2:0] regIdx_t;
	typedef logic [4:0] opcode_t;

	// Opcode field, instr[15:11]
	localparam opcode_t OpHalt  = 5'b00000;
	localparam opcode_t OpNop   = 5'b00001;
	localparam opcode_t OpJ     = 5'b00100;
	localparam opcode_t OpAddi  = 5'b01000;
	localparam opcode_t OpSubi  = 5'b01001;
	localparam opcode_t OpXori  = 5'b01010;
	localparam opcode_t OpAndni = 5'b01011;
	localparam opcode_t OpBeqz  = 5'b01100;
	localparam opcode_t OpBnez  = 5'b01101;
	localparam opcode_t OpSt    = 5'b10000;
	localparam opcode_t OpLd    = 5'b10001;
	localparam opcode_t OpSlbi  = 5'b10010;
	localparam opcode_t OpLbi   = 5'b11000;
	// R-format, function in instr[1:0]
	localparam opcode_t OpRtype = 5'b11011;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluXor,
		aluAndn,
		aluPassB,
		aluShiftOr
	} aluOp_t;

	typedef enum logic [1:0] {
		stIdle,
		stRunning,
		stHalted
	} runState_t;

	// Immediate select between control and decode
	localparam logic [1:0] ImmSext5  = 2'd0;
	localparam logic [1:0] ImmZext5  = 2'd1;
	localparam logic [1:0] ImmSext8  = 2'd2;
	localparam logic [1:0] ImmSext11 = 2'd3;

	// Write-back destination field
	localparam logic [1:0] RegDstRd = 2'd0;
	localparam logic [1:0] RegDstRt = 2'd1;
	localparam logic [1:0] RegDstRs = 2'd2;

	// Host address map
	localparam int ImemSelBit = 12;
	localparam int DmemSelBit = 13;
	localparam word_t StatusAddr = 16'h0000;
	localparam int RunBit = 0;
	localparam int HaltedBit = 1;
	localparam int ErrBit = 2;

endpackage

/* source/fetch.sv */
/* Program counter and instruction memory; the host fills the memory over APB
   before a run and the core reads it asynchronously at the PC. */
module fetch import procPkg::*; #(
	parameter int ImemAw = 8
) (
	input  logic  clk,
	input  logic  arstN,
	input  logic  run,
	input  logic  start,
	input  word_t pcNext,
	input  logic  imemWe,
	input  word_t imemAddr,
	input  word_t imemData,
	output word_t pc2,
	output word_t instr
);

	word_t pc;
	word_t imem [2**ImemAw];

	// Host write port, one word per access
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr[ImemAw:1]] <= imemData;
		end
	end

	// Start wins over run so a restart always lands on address 0
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (run) begin
			pc <= pcNext;
		end
	end

	// Byte addressed, word aligned
	assign instr = imem[pc[ImemAw:1]];
	assign pc2 = pc + 16'd2;

	// Stopped core must not drift
	pcHold: assert property (@(posedge clk) disable iff (!arstN)
		!run && !start |=> $stable(pc));

endmodule

/* source/control.sv */
/* Opcode decode for the single-cycle core. Purely combinational, it drives
   the datapath selects and flags undefined opcodes. */
module control import procPkg::*; (
	input  word_t      instr,
	output aluOp_t     aluOp,
	output logic       aluSrc,
	output logic [1:0] immSel,
	output logic [1:0] regDst,
	output logic       regWrite,
	output logic       memRead,
	output logic       memWrite,
	output logic       memToReg,
	output logic       branch,
	output logic       branchNz,
	output logic       jump,
	output logic       halt,
	output logic       err
);

	opcode_t opcode;
	logic [1:0] func;

	assign opcode = instr[15:11];
	assign func = instr[1:0];

	always_comb begin
		// Defaults behave like NOP
		aluOp = aluAdd;
		aluSrc = 1'b0;
		immSel = ImmSext5;
		regDst = RegDstRd;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		branch = 1'b0;
		branchNz = 1'b0;
		jump = 1'b0;
		halt = 1'b0;
		err = 1'b0;
		case (opcode)
			OpHalt: halt = 1'b1;
			OpNop: ;
			OpAddi, OpSubi, OpXori, OpAndni: begin
				aluSrc = 1'b1;
				regDst = RegDstRt;
				regWrite = 1'b1;
				// Logic immediates are zero extended
				immSel = opcode[1] ? ImmZext5 : ImmSext5;
				aluOp = aluOp_t'({1'b0, opcode[1:0]});
			end
			OpRtype: begin
				regWrite = 1'b1;
				aluOp = aluOp_t'({1'b0, func});
			end
			OpLbi, OpSlbi: begin
				aluSrc = 1'b1;
				immSel = ImmSext8;
				regDst = RegDstRs;
				regWrite = 1'b1;
				aluOp = (opcode == OpLbi) ? aluPassB : aluShiftOr;
			end
			OpLd: begin
				aluSrc = 1'b1;
				regDst = RegDstRt;
				regWrite = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
			end
			OpSt: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			OpBeqz, OpBnez: begin
				immSel = ImmSext8;
				branch = 1'b1;
				branchNz = opcode[0];
			end
			OpJ: begin
				immSel = ImmSext11;
				jump = 1'b1;
			end
			// Undefined, all write enables stay low
			default: err = 1'b1;
		endcase
		errNoWrite: assert (!(err && regWrite));
	end

endmodule

/* source/decode.sv */
/* Register file, immediate extension and write-back select. Reads are
   asynchronous; the single write port commits at the clock edge while running. */
module decode import procPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  word_t      instr,
	input  logic [1:0] immSel,
	input  logic [1:0] regDst,
	input  logic       regWrite,
	input  logic       memToReg,
	input  logic       run,
	input  word_t      exOut,
	input  word_t      rdD,
	output word_t      rd1,
	output word_t      rd2,
	output word_t      imm
);

	word_t regs [8];
	regIdx_t wrIdx;
	word_t writeData;

	// Rs and Rt read ports
	assign rd1 = regs[instr[10:8]];
	assign rd2 = regs[instr[7:5]];

	always_comb begin
		case (regDst)
			RegDstRt: wrIdx = instr[7:5];
			RegDstRs: wrIdx = instr[10:8];
			default:  wrIdx = instr[4:2];
		endcase
	end

	// Write-back mux, loads take memory data
	assign writeData = memToReg ? rdD : exOut;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && run) begin
			regs[wrIdx] <= writeData;
		end
	end

	always_comb begin
		case (immSel)
			ImmZext5:  imm = {11'b0, instr[4:0]};
			ImmSext8:  imm = {{8{instr[7]}}, instr[7:0]};
			ImmSext11: imm = {{5{instr[10]}}, instr[10:0]};
			default:   imm = {{11{instr[4]}}, instr[4:0]};
		endcase
	end

endmodule

/* source/execute.sv */
/* ALU, branch condition and next-PC adder. All combinational; results feed
   memory and write-back in the same cycle. */
module execute import procPkg::*; (
	input  word_t  pc2,
	input  word_t  rd1,
	input  word_t  rd2,
	input  word_t  imm,
	input  aluOp_t aluOp,
	input  logic   aluSrc,
	input  logic   branch,
	input  logic   branchNz,
	input  logic   jump,
	output word_t  exOut,
	output word_t  pcNext
);

	word_t opA;
	word_t opB;
	logic rsZero;
	logic taken;

	assign opA = rd1;
	assign opB = aluSrc ? imm : rd2;

	always_comb begin
		case (aluOp)
			aluAdd:     exOut = opA + opB;
			// Reverse subtract, B minus A
			aluSub:     exOut = opB - opA;
			aluXor:     exOut = opA ^ opB;
			aluAndn:    exOut = opA & ~opB;
			aluPassB:   exOut = opB;
			// SLBI, low byte of B is taken unsigned
			aluShiftOr: exOut = {opA[7:0], opB[7:0]};
			default:    exOut = '0;
		endcase
	end

	// Branches test Rs only
	assign rsZero = (rd1 == '0);
	assign taken = branch && (branchNz ? !rsZero : rsZero);

	// Offsets are relative to the following instruction
	assign pcNext = (jump || taken) ? pc2 + imm : pc2;

endmodule

/* source/memory.sv */
/* Data memory of the core, with a synchronous core write and two asynchronous
   reads, one for loads and one for host readback. */
module memory import procPkg::*; #(
	parameter int DmemAw = 8
) (
	input  logic  clk,
	input  logic  run,
	input  word_t exOut,
	input  word_t dataIn,
	input  logic  memRead,
	input  logic  memWrite,
	output word_t rdD,
	input  word_t dmemHostAddr,
	output word_t dmemHostData
);

	word_t dmem [2**DmemAw];
	logic [DmemAw-1:0] coreIdx;

	// Word index from the byte address
	assign coreIdx = exOut[DmemAw:1];

	always_ff @(posedge clk) begin
		if (memWrite && run) begin
			dmem[coreIdx] <= dataIn;
		end
	end

	// Zero when not loading keeps the write-back mux quiet
	assign rdD = memRead ? dmem[coreIdx] : '0;

	assign dmemHostData = dmem[dmemHostAddr[DmemAw:1]];

endmodule

/* source/hostPort.sv */
/* APB slave for program load, run control and result readback, with the
   idle/running/halted machine that gates the core. */
module hostPort import procPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  logic  psel,
	input  logic  penable,
	input  logic  pwrite,
	input  word_t paddr,
	input  word_t pwdata,
	output word_t prdata,
	output logic  pready,
	input  logic  halt,
	input  logic  err,
	input  word_t dmemHostData,
	output logic  run,
	output logic  start,
	output logic  imemWe,
	output word_t imemAddr,
	output word_t imemData,
	output word_t dmemHostAddr
);

	runState_t state;
	logic errSticky;
	logic apbWr;
	logic statusWr;
	word_t status;

	// No wait states
	assign pready = 1'b1;
	assign apbWr = psel && penable && pwrite;
	assign statusWr = apbWr && (paddr == StatusAddr);

	// Program load is locked out while the core runs
	assign imemWe = apbWr && paddr[ImemSelBit] && (state != stRunning);
	assign imemAddr = paddr;
	assign imemData = pwdata;
	assign dmemHostAddr = paddr;

	// Drop run in the stopping cycle so the PC stays on that instruction
	assign run = (state == stRunning) && !halt && !err;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			start <= 1'b0;
			errSticky <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				stIdle, stHalted: if (start) state <= stRunning;
				stRunning: begin
					if (halt || err) begin
						state <= stHalted;
						errSticky <= err;
					end else if (statusWr && !pwdata[RunBit]) begin
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
			// Run request, one start pulse then running
			if (statusWr && pwdata[RunBit] && (state != stRunning) && !start) begin
				start <= 1'b1;
				errSticky <= 1'b0;
			end
		end
	end

	always_comb begin
		status = '0;
		status[RunBit] = run;
		status[HaltedBit] = (state == stHalted);
		status[ErrBit] = errSticky;
	end

	// Read data straight from the selected source
	assign prdata = paddr[DmemSelBit] ? dmemHostData :
		(paddr == StatusAddr) ? status : '0;

	apbSetup: assert property (@(posedge clk) disable iff (!arstN) penable |-> psel);

endmodule

/* source/proc.sv */
/* Top level of the single-cycle processor. Connects the stages to the APB
   host port and sets the memory sizes. */
module proc import procPkg::*; #(
	parameter int ImemAw = 8,
	parameter int DmemAw = 8
) (
	input  logic  clk,
	input  logic  arstN,
	input  logic  psel,
	input  logic  penable,
	input  logic  pwrite,
	input  word_t paddr,
	input  word_t pwdata,
	output word_t prdata,
	output logic  pready,
	output logic  err
);

	word_t instr, pc2, pcNext, rd1, rd2, imm, exOut, rdD;
	word_t imemAddr, imemData, dmemHostAddr, dmemHostData;
	aluOp_t aluOp;
	logic [1:0] immSel, regDst;
	logic aluSrc, regWrite, memRead, memWrite, memToReg;
	logic branch, branchNz, jump, halt;
	logic run, start, imemWe;

	// Fetch
	fetch #(.ImemAw(ImemAw)) fetch0 (.clk(clk), .arstN(arstN), .run(run), .start(start),
		.pcNext(pcNext), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.pc2(pc2), .instr(instr));

	// Control, err leaves the core from here
	control ctrl (.instr(instr), .aluOp(aluOp), .aluSrc(aluSrc), .immSel(immSel),
		.regDst(regDst), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
		.memToReg(memToReg), .branch(branch), .branchNz(branchNz), .jump(jump),
		.halt(halt), .err(err));

	// Decode and write-back
	decode decode0 (.clk(clk), .arstN(arstN), .instr(instr), .immSel(immSel),
		.regDst(regDst), .regWrite(regWrite), .memToReg(memToReg), .run(run),
		.exOut(exOut), .rdD(rdD), .rd1(rd1), .rd2(rd2), .imm(imm));

	// Execute
	execute ex (.pc2(pc2), .rd1(rd1), .rd2(rd2), .imm(imm), .aluOp(aluOp), .aluSrc(aluSrc),
		.branch(branch), .branchNz(branchNz), .jump(jump), .exOut(exOut), .pcNext(pcNext));

	// Data memory, store data is Rt
	memory #(.DmemAw(DmemAw)) memory0 (.clk(clk), .run(run), .exOut(exOut), .dataIn(rd2),
		.memRead(memRead), .memWrite(memWrite), .rdD(rdD), .dmemHostAddr(dmemHostAddr),
		.dmemHostData(dmemHostData));

	// Host
	hostPort host (.clk(clk), .arstN(arstN), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.halt(halt), .err(err), .dmemHostData(dmemHostData), .run(run), .start(start),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.dmemHostAddr(dmemHostAddr));

endmodule

/* verif/procTb.sv */
/* Testbench for the single-cycle core. Loads small programs over APB, runs them
   to HALT and checks data memory, status and the err port against the ISA rules. */
module procTb import procPkg::*;;

	localparam int CycleLimit = 2000;
	localparam word_t ImemBase = 16'h1000;
	localparam word_t DmemBase = 16'h2000;

	logic clk;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	word_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic err;

	int seed;
	int cycles;
	int errors;
	int tests;
	word_t prog[$];

	proc #(.ImemAw(8), .DmemAw(8)) i_proc (.clk(clk), .arstN(arstN), .psel(psel),
		.penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .err(err));

	always #5 clk = ~clk;

	// Run limit covers five load, run and readback sequences with margin
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Instruction encoders, field layout from the ISA
	function automatic word_t immInstr(opcode_t op, regIdx_t rs, regIdx_t rt, logic [4:0] k);
		return {op, rs, rt, k};
	endfunction

	function automatic word_t regInstr(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [1:0] f);
		return {OpRtype, rs, rt, rd, f};
	endfunction

	function automatic word_t byteInstr(opcode_t op, regIdx_t rs, logic [7:0] k);
		return {op, rs, k};
	endfunction

	function automatic word_t jumpInstr(logic [10:0] k);
		return {OpJ, k};
	endfunction

	// LBI high byte then SLBI low byte
	task automatic buildConst(regIdx_t rs, word_t v);
		prog.push_back(byteInstr(OpLbi, rs, v[15:8]));
		prog.push_back(byteInstr(OpSlbi, rs, v[7:0]));
	endtask

	// No wait states, so every access phase sees pready high
	task automatic verifyReady();
		assert (pready === 1'b1) else begin
			$display("ERROR t=%0t pready got %b expected 1", $time, pready);
			errors++;
		end
	endtask

	task automatic apbWrite(word_t addr, word_t data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#1;
		verifyReady();
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// Sampled mid access phase, away from the clock edge
	task automatic apbRead(word_t addr, output word_t data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata;
		verifyReady();
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic readData(word_t byteAddr, output word_t data);
		apbRead(DmemBase | byteAddr, data);
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			apbWrite(ImemBase + 16'(2 * i), prog[i]);
		end
	endtask

	// Run write, then poll status until halted
	task automatic runProgram();
		word_t s;
		s = '0;
		apbWrite(StatusAddr, 16'h0001);
		while (!s[HaltedBit]) begin
			apbRead(StatusAddr, s);
		end
	endtask

	task automatic checkEqual(string name, word_t got, word_t exp);
		assert (got === exp) else begin
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkMem(string name, word_t byteAddr, word_t exp);
		word_t d;
		readData(byteAddr, d);
		checkEqual(name, d, exp);
	endtask

	task automatic finishTest(string name, int errsBefore);
		tests++;
		if (errors == errsBefore) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: mismatch", name);
		end
	endtask

	initial begin
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t s;
		word_t kSext;
		word_t kZext;
		logic [4:0] k;
		logic [7:0] n;
		int r;
		int e0;
		clk = 1'b0;
		arstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'hc75d9f9a;
		cycles = 0;
		errors = 0;
		tests = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		// Arithmetic and logic, results at bytes 0..14
		e0 = errors;
		r = $random(seed);
		a = r[15:0];
		r = $random(seed);
		b = r[15:0];
		r = $random(seed);
		k = r[4:0];
		kSext = {{11{k[4]}}, k};
		kZext = {11'b0, k};
		prog.delete();
		buildConst(3'd1, a);
		buildConst(3'd2, b);
		for (int f = 0; f < 4; f++) begin
			prog.push_back(regInstr(3'd1, 3'd2, 3'd3, 2'(f)));
			prog.push_back(immInstr(OpSt, 3'd0, 3'd3, 5'(2 * f)));
		end
		prog.push_back(immInstr(OpAddi, 3'd1, 3'd3, k));
		prog.push_back(immInstr(OpSt, 3'd0, 3'd3, 5'd8));
		prog.push_back(immInstr(OpSubi, 3'd1, 3'd3, k));
		prog.push_back(immInstr(OpSt, 3'd0, 3'd3, 5'd10));
		prog.push_back(immInstr(OpXori, 3'd1, 3'd3, k));
		prog.push_back(immInstr(OpSt, 3'd0, 3'd3, 5'd12));
		prog.push_back(immInstr(OpAndni, 3'd1, 3'd3, k));
		prog.push_back(immInstr(OpSt, 3'd0, 3'd3, 5'd14));
		prog.push_back(16'h0000);
		loadProgram();
		runProgram();
		checkMem("add", 16'd0, a + b);
		// Reverse subtract, Rt minus Rs
		checkMem("sub", 16'd2, b - a);
		checkMem("xor", 16'd4, a ^ b);
		checkMem("andn", 16'd6, a & ~b);
		checkMem("addi", 16'd8, a + kSext);
		checkMem("subi", 16'd10, kSext - a);
		checkMem("xori", 16'd12, a ^ kZext);
		checkMem("andni", 16'd14, a & ~kZext);
		finishTest("alu", e0);

		// Branches and jumps, markers at bytes 32..38
		e0 = errors;
		r = $random(seed);
		n = 8'd3 + {6'b0, r[1:0]};
		prog.delete();
		prog.push_back(byteInstr(OpLbi, 3'd7, 8'd32));
		prog.push_back(byteInstr(OpLbi, 3'd4, n));
		prog.push_back(byteInstr(OpLbi, 3'd5, 8'd0));
		prog.push_back(immInstr(OpAddi, 3'd5, 3'd5, 5'd1));
		prog.push_back(immInstr(OpAddi, 3'd4, 3'd4, 5'h1f));
		// Back to the ADDI of r5, three words up
		prog.push_back(byteInstr(OpBnez, 3'd4, 8'hfa));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd5, 5'd0));
		prog.push_back(byteInstr(OpLbi, 3'd3, 8'h11));
		prog.push_back(byteInstr(OpBeqz, 3'd0, 8'd2));
		prog.push_back(byteInstr(OpLbi, 3'd3, 8'h7f));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd3, 5'd2));
		// r7 holds 32, so this one falls through
		prog.push_back(byteInstr(OpBeqz, 3'd7, 8'd2));
		prog.push_back(byteInstr(OpLbi, 3'd3, 8'h22));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd3, 5'd4));
		prog.push_back(jumpInstr(11'd2));
		prog.push_back(byteInstr(OpLbi, 3'd3, 8'h7e));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd3, 5'd6));
		prog.push_back(16'h0000);
		loadProgram();
		runProgram();
		checkMem("loopCount", 16'd32, {8'b0, n});
		checkMem("beqzTaken", 16'd34, 16'h0011);
		checkMem("beqzNotTaken", 16'd36, 16'h0022);
		checkMem("jump", 16'd38, 16'h0022);
		finishTest("branch", e0);

		// Loads, base r7 at byte 64, one negative offset
		e0 = errors;
		r = $random(seed);
		c = r[15:0];
		r = $random(seed);
		d = r[15:0];
		prog.delete();
		prog.push_back(byteInstr(OpLbi, 3'd7, 8'd64));
		prog.push_back(byteInstr(OpLbi, 3'd6, 8'd72));
		buildConst(3'd1, c);
		buildConst(3'd2, d);
		prog.push_back(immInstr(OpSt, 3'd7, 3'd1, 5'd0));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd2, 5'd2));
		prog.push_back(immInstr(OpLd, 3'd7, 3'd4, 5'd0));
		prog.push_back(immInstr(OpLd, 3'd7, 3'd5, 5'd2));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd4, 5'd4));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd5, 5'd6));
		prog.push_back(immInstr(OpLd, 3'd6, 3'd3, 5'h18));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd3, 5'd8));
		prog.push_back(16'h0000);
		loadProgram();
		runProgram();
		checkMem("store0", 16'd64, c);
		checkMem("store1", 16'd66, d);
		checkMem("load0", 16'd68, c);
		checkMem("load1", 16'd70, d);
		checkMem("loadNeg", 16'd72, c);
		finishTest("load", e0);

		// Halt and status, then a restart of the same program
		e0 = errors;
		apbRead(StatusAddr, s);
		checkEqual("status", s, 16'h0002);
		repeat (10) @(posedge clk);
		// Past HALT lies the old J test store of 8'h7e to byte 70
		checkMem("heldMem", 16'd70, d);
		// Word 0 now sets base 80, only a run from address 0 puts copies there
		apbWrite(ImemBase, byteInstr(OpLbi, 3'd7, 8'd80));
		runProgram();
		apbRead(StatusAddr, s);
		checkEqual("statusRerun", s, 16'h0002);
		checkMem("rerun0", 16'd84, c);
		checkMem("rerun1", 16'd86, d);
		checkMem("rerunNeg", 16'd88, c);
		checkMem("rerunAlu", 16'd0, a + b);
		finishTest("halt", e0);

		// Undefined third word, r7 is 80 and r1, r2 still hold from the rerun
		e0 = errors;
		prog.delete();
		prog.push_back(immInstr(OpSt, 3'd7, 3'd1, 5'd10));
		prog.push_back(immInstr(OpSt, 3'd7, 3'd2, 5'd12));
		prog.push_back(16'hf800);
		// Would put c over the copy of d at byte 86
		prog.push_back(immInstr(OpSt, 3'd7, 3'd1, 5'd6));
		prog.push_back(16'h0000);
		loadProgram();
		runProgram();
		apbRead(StatusAddr, s);
		checkEqual("statusErr", s, 16'h0006);
		checkEqual("errPort", {15'b0, err}, 16'h0001);
		checkMem("errStore0", 16'd90, c);
		checkMem("errStore1", 16'd92, d);
		checkMem("errNoStore", 16'd86, d);
		finishTest("undefined", e0);

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* files.f */
source/procPkg.sv
source/fetch.sv
source/control.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/hostPort.sv
source/proc.sv
verif/procTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module procTb -o procSim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/procSim > sim.log 2>&1
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed" || {
	echo "Simulation failed, see sim.log"
	exit 1
}
